/* rtl/vecPkg.sv */
package vecPkg;

	// ------------------------------
	// Widths
	// ------------------------------
	typedef logic [31:0]        wordType;    // Wishbone data word
	typedef logic [4:0]         regAdrType;  // Word address
	typedef logic signed [15:0] compType;    // Vector or matrix component
	typedef logic signed [43:0] accType;     // MAC accumulator
	typedef logic [24:0]        instrType;   // Command word
	typedef logic [5:0]         opcodeType;

	// Instruction fields
	localparam int instrLmBit    = 10;  // Clamp IR low side to zero
	localparam int instrTransBit = 13;  // Add TR
	localparam int instrVecLsb   = 15;  // 2-bit vector select
	localparam int instrSfBit    = 19;  // 12-bit fraction shift

	localparam opcodeType opMvmva = 6'h12;
	localparam opcodeType opSqr   = 6'h28;

	// ------------------------------
	// Register map
	// ------------------------------
	// V0..V2 x,y,z sit below the matrix
	localparam regAdrType adrMatBase = 5'd9;   // R11..R33 row-major
	localparam regAdrType adrTrBase  = 5'd18;  // TRX..TRZ
	localparam regAdrType adrIrBase  = 5'd21;  // IR1..IR3
	localparam regAdrType adrMacBase = 5'd24;  // MAC1..MAC3
	localparam regAdrType adrFlag    = 5'd27;  // Saturation bits
	localparam regAdrType adrCmd     = 5'd28;  // Start on write, busy on read

	// ------------------------------
	// Microcode
	// ------------------------------
	localparam logic modeMat = 1'b0;  // Matrix times vector
	localparam logic modeSqr = 1'b1;  // IR times IR

	typedef struct packed {
		logic       accClear;  // First column of a row
		logic       mode;
		logic [1:0] row;
		logic [1:0] col;
		logic       addTrans;  // Preload TR on this step
		logic       endRow;    // Write-back follows
		logic       last;
	} microStepType;

	typedef enum logic {
		seqIdle,
		seqRun
	} seqStateType;

endpackage

/* rtl/vecRegFile.sv */
module vecRegFile import vecPkg::*; (
	input  logic      i_clk,
	input  logic      i_arstN,
	// Host port
	input  logic      i_wbCyc,
	input  logic      i_wbStb,
	input  logic      i_wbWe,
	input  regAdrType i_wbAdr,
	input  wordType   i_wbDat,
	output wordType   o_wbDat,
	output logic      o_wbAck,
	// Sequencer side
	input  logic      i_busy,
	output logic      o_start,
	output instrType  o_instr,
	// Datapath side
	input  logic [1:0] i_rowSel,
	input  logic [1:0] i_colSel,
	input  logic [1:0] i_vecSel,
	input  logic       i_wbStrobe,
	input  logic [1:0] i_wbRow,
	input  wordType    i_macIn,
	input  compType    i_irIn,
	input  logic       i_satIn,
	output compType    o_matElem,
	output compType    o_vecElem,
	output compType    o_irElem,
	output wordType    o_trElem
);

	compType  vecQ [0:8];   // V0..V2
	compType  matQ [0:8];
	wordType  trQ  [0:2];
	compType  irQ  [0:2];
	compType  irSnapQ [0:2];  // IR as seen at instruction start
	wordType  macQ [0:2];
	logic [2:0] flagQ;
	instrType instrQ;
	wordType  rdDataQ;
	wordType  rdData;
	logic     ackQ, startQ;

	logic isVec, isMat, isTr, isIr, isMac, isFlag, isCmd;
	logic [3:0] vecOff, matOff;
	logic [1:0] trOff, irOff, macOff;
	logic accept, hostWr, cmdWr;
	logic [3:0] matIdx, vecIdx;

	// ------------------------------
	// Address decode
	// ------------------------------
	assign isVec  = (i_wbAdr < adrMatBase);
	assign isMat  = (i_wbAdr >= adrMatBase) && (i_wbAdr < adrTrBase);
	assign isTr   = (i_wbAdr >= adrTrBase) && (i_wbAdr < adrIrBase);
	assign isIr   = (i_wbAdr >= adrIrBase) && (i_wbAdr < adrMacBase);
	assign isMac  = (i_wbAdr >= adrMacBase) && (i_wbAdr < adrFlag);
	assign isFlag = (i_wbAdr == adrFlag);
	assign isCmd  = (i_wbAdr == adrCmd);

	assign vecOff = 4'(i_wbAdr);
	assign matOff = 4'(i_wbAdr - adrMatBase);
	assign trOff  = 2'(i_wbAdr - adrTrBase);
	assign irOff  = 2'(i_wbAdr - adrIrBase);
	assign macOff = 2'(i_wbAdr - adrMacBase);

	// Busy holds off everything but the CMD poll
	assign accept = i_wbCyc && i_wbStb && !ackQ && (!i_busy || (!i_wbWe && isCmd));
	assign hostWr = accept && i_wbWe;
	assign cmdWr  = hostWr && isCmd;

	always_comb begin
		rdData = '0;  // Unmapped reads as zero
		if (isVec)       rdData = wordType'(vecQ[vecOff]);  // Sign-extended
		else if (isMat)  rdData = wordType'(matQ[matOff]);
		else if (isTr)   rdData = trQ[trOff];
		else if (isIr)   rdData = wordType'(irQ[irOff]);
		else if (isMac)  rdData = macQ[macOff];
		else if (isFlag) rdData = {29'd0, flagQ};
		else if (isCmd)  rdData = {31'd0, i_busy};
	end

	// ------------------------------
	// Control state
	// ------------------------------
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			ackQ   <= 1'b0;
			startQ <= 1'b0;
			flagQ  <= '0;
		end else begin
			ackQ   <= accept;  // Single-cycle ack
			startQ <= cmdWr;   // Start pulse in the ack cycle
			if (startQ)
				flagQ <= '0;
			else if (i_wbStrobe)
				flagQ[i_wbRow] <= i_satIn;
		end
	end

	// Operand and result storage
	always_ff @(posedge i_clk) begin
		if (accept && !i_wbWe)
			rdDataQ <= rdData;
		if (hostWr) begin
			if (isVec) vecQ[vecOff] <= i_wbDat[15:0];
			if (isMat) matQ[matOff] <= i_wbDat[15:0];
			if (isTr)  trQ[trOff]   <= i_wbDat;
			if (isIr)  irQ[irOff]   <= i_wbDat[15:0];
			if (isMac) macQ[macOff] <= i_wbDat;
			if (isCmd) instrQ       <= i_wbDat[24:0];
		end
		if (i_wbStrobe) begin  // Datapath wins, host is held off anyway
			macQ[i_wbRow] <= i_macIn;
			irQ[i_wbRow]  <= i_irIn;
		end
		if (startQ)
			irSnapQ <= irQ;  // Rows written back early must not feed later rows
	end

	// ------------------------------
	// Operand select
	// ------------------------------
	assign matIdx = {2'b00, i_rowSel} * 4'd3 + {2'b00, i_colSel};
	assign vecIdx = {2'b00, i_vecSel} * 4'd3 + {2'b00, i_colSel};

	assign o_matElem = matQ[matIdx];
	assign o_vecElem = (i_vecSel == 2'd3) ? irSnapQ[i_colSel] : vecQ[vecIdx];  // 3 selects IR
	assign o_irElem  = irSnapQ[i_rowSel];
	assign o_trElem  = trQ[i_rowSel];

	assign o_wbDat = rdDataQ;
	assign o_wbAck = ackQ;
	assign o_start = startQ;
	assign o_instr = instrQ;

	// Ack only answers a request seen on the previous edge
	ackNeedsReq: assert property (@(posedge i_clk) disable iff (!i_arstN)
		o_wbAck |-> $past(i_wbCyc && i_wbStb));

endmodule

/* rtl/vecSequencer.sv */
module vecSequencer import vecPkg::*; (
	input  logic         i_clk,
	input  logic         i_arstN,
	input  logic         i_start,
	input  opcodeType    i_opcode,
	output logic         o_busy,
	output microStepType o_step
);

	localparam int romDepth = 13;

	// ROM layout
	localparam logic [4:0] romMvmva = 5'd0;   // 9 steps
	localparam logic [4:0] romSqr   = 5'd9;   // 3 steps
	localparam logic [4:0] romNop   = 5'd12;  // 1 step

	seqStateType  stateQ;
	logic [4:0]   pcQ;
	logic         drainQ;  // Waiting on the final write-back
	logic [4:0]   startAdr;
	microStepType romStep;

	// One MVMVA step, column 0 opens the row and column 2 closes it
	function automatic microStepType mvStep(input logic [1:0] row, input logic [1:0] col,
		input logic last);
		microStepType s;
		s          = '0;
		s.mode     = modeMat;
		s.row      = row;
		s.col      = col;
		s.accClear = (col == 2'd0);
		s.addTrans = (col == 2'd0);
		s.endRow   = (col == 2'd2);
		s.last     = last;
		return s;
	endfunction

	// One SQR step per component
	function automatic microStepType sqStep(input logic [1:0] row, input logic last);
		microStepType s;
		s          = '0;
		s.mode     = modeSqr;
		s.row      = row;
		s.accClear = 1'b1;
		s.endRow   = 1'b1;
		s.last     = last;
		return s;
	endfunction

	// ------------------------------
	// Start decode and ROM
	// ------------------------------
	always_comb begin
		case (i_opcode)
			opMvmva: startAdr = romMvmva;
			opSqr:   startAdr = romSqr;
			default: startAdr = romNop;  // Unknown opcode
		endcase
	end

	always_comb begin
		romStep = '0;
		case (pcQ)
			5'd0:  romStep = mvStep(2'd0, 2'd0, 1'b0);
			5'd1:  romStep = mvStep(2'd0, 2'd1, 1'b0);
			5'd2:  romStep = mvStep(2'd0, 2'd2, 1'b0);
			5'd3:  romStep = mvStep(2'd1, 2'd0, 1'b0);
			5'd4:  romStep = mvStep(2'd1, 2'd1, 1'b0);
			5'd5:  romStep = mvStep(2'd1, 2'd2, 1'b0);
			5'd6:  romStep = mvStep(2'd2, 2'd0, 1'b0);
			5'd7:  romStep = mvStep(2'd2, 2'd1, 1'b0);
			5'd8:  romStep = mvStep(2'd2, 2'd2, 1'b1);
			5'd9:  romStep = sqStep(2'd0, 1'b0);
			5'd10: romStep = sqStep(2'd1, 1'b0);
			5'd11: romStep = sqStep(2'd2, 1'b1);
			5'd12: romStep.last = 1'b1;  // NOP does nothing else
			default: romStep = '0;
		endcase
	end

	// ------------------------------
	// PC and busy
	// ------------------------------
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			stateQ <= seqIdle;
			pcQ    <= '0;
			drainQ <= 1'b0;
		end else begin
			case (stateQ)
				seqIdle: if (i_start) begin
					stateQ <= seqRun;
					pcQ    <= startAdr;
					drainQ <= 1'b0;
				end
				seqRun: begin
					if (drainQ) begin
						stateQ <= seqIdle;  // Write-back done
						drainQ <= 1'b0;
					end else if (romStep.last) begin
						if (romStep.endRow)
							drainQ <= 1'b1;     // One more cycle for the last row
						else
							stateQ <= seqIdle;  // NOP, nothing to write
					end else begin
						pcQ <= pcQ + 5'd1;
					end
				end
				default: stateQ <= seqIdle;
			endcase
		end
	end

	assign o_busy = (stateQ == seqRun);
	assign o_step = (o_busy && !drainQ) ? romStep : '0;  // Idle steps are all zero

	pcInRom: assert property (@(posedge i_clk) disable iff (!i_arstN)
		o_busy |-> (pcQ < 5'(romDepth)));

	// Busy only drops after the program has issued its last step
	busyEndsOnLast: assert property (@(posedge i_clk) disable iff (!i_arstN)
		$fell(o_busy) |-> ($past(o_step.last) || $past(drainQ)));

endmodule

/* rtl/vecDatapath.sv */
module vecDatapath import vecPkg::*; #(
	parameter int fracBits = 12
) (
	input  logic         i_clk,
	input  logic         i_arstN,
	input  microStepType i_step,
	input  compType      i_matElem,
	input  compType      i_vecElem,
	input  compType      i_irElem,
	input  wordType      i_trElem,
	input  logic         i_sf,
	input  logic         i_lm,
	input  logic         i_transEn,
	output logic         o_wbStrobe,
	output logic [1:0]   o_wbRow,
	output wordType      o_macOut,
	output compType      o_irOut,
	output logic         o_satOut
);

	compType mulA, mulB;
	logic signed [31:0] product;
	accType  preload, accBase, accNext, accQ;
	accType  shifted, irLo;
	compType irVal;
	logic    sat;
	logic    strobeQ;
	logic [1:0] rowQ;
	wordType macQ;
	compType irQ;
	logic    satQ;

	// ------------------------------
	// Multiply-accumulate
	// ------------------------------
	always_comb begin
		if (i_step.mode == modeSqr) begin
			mulA = i_irElem;
			mulB = i_irElem;
		end else begin
			mulA = i_matElem;
			mulB = i_vecElem;
		end
	end

	assign product = mulA * mulB;  // Single 16x16 multiplier

	// TR enters at the fraction position so sf lines it up again
	assign preload = (i_step.addTrans && i_transEn) ?
		(accType'(signed'(i_trElem)) <<< fracBits) : '0;

	assign accBase = i_step.accClear ? preload : accQ;
	assign accNext = accBase + accType'(product);

	// Each row opens with accClear so idle cycles leave no trace
	always_ff @(posedge i_clk) begin
		accQ <= accNext;
	end

	// ------------------------------
	// Shift and saturate
	// ------------------------------
	assign shifted = i_sf ? (accNext >>> fracBits) : accNext;
	assign irLo    = i_lm ? '0 : accType'(-32768);  // lm clamps to zero

	always_comb begin
		sat   = 1'b0;
		irVal = shifted[15:0];
		if (shifted > accType'(32767)) begin
			irVal = 16'sd32767;
			sat   = 1'b1;
		end else if (shifted < irLo) begin
			irVal = irLo[15:0];
			sat   = 1'b1;
		end
	end

	// Write-back one cycle after endRow
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			strobeQ <= 1'b0;
			rowQ    <= '0;
		end else begin
			strobeQ <= i_step.endRow;
			if (i_step.endRow)
				rowQ <= i_step.row;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_step.endRow) begin
			macQ <= shifted[31:0];  // MAC keeps low word
			irQ  <= irVal;
			satQ <= sat;
		end
	end

	assign o_wbStrobe = strobeQ;
	assign o_wbRow    = rowQ;
	assign o_macOut   = macQ;
	assign o_irOut    = irQ;
	assign o_satOut   = satQ;

	// ROM never addresses a fourth row
	rowInRange: assert property (@(posedge i_clk) disable iff (!i_arstN)
		o_wbStrobe |-> (o_wbRow != 2'd3));

endmodule

/* rtl/vecEngine.sv */
module vecEngine import vecPkg::*; #(
	parameter int fracBits = 12  // Fraction width for sf
) (
	input  logic      i_clk,
	input  logic      i_arstN,
	input  logic      i_wbCyc,
	input  logic      i_wbStb,
	input  logic      i_wbWe,
	input  regAdrType i_wbAdr,
	input  wordType   i_wbDat,
	output wordType   o_wbDat,
	output logic      o_wbAck
);

	// ------------------------------
	// Interconnect
	// ------------------------------
	logic         start;
	instrType     instr;
	logic         busy;
	microStepType step;
	compType      matElem, vecElem, irElem;
	wordType      trElem;
	logic         wbStrobe;
	logic [1:0]   wbRow;
	wordType      macData;
	compType      irData;
	logic         satBit;

	// Host registers and operand buffer
	vecRegFile u_regFile (
		.i_clk      (i_clk),
		.i_arstN    (i_arstN),
		.i_wbCyc    (i_wbCyc),
		.i_wbStb    (i_wbStb),
		.i_wbWe     (i_wbWe),
		.i_wbAdr    (i_wbAdr),
		.i_wbDat    (i_wbDat),
		.o_wbDat    (o_wbDat),
		.o_wbAck    (o_wbAck),
		.i_busy     (busy),
		.o_start    (start),
		.o_instr    (instr),
		.i_rowSel   (step.row),
		.i_colSel   (step.col),
		.i_vecSel   (instr[instrVecLsb +: 2]),
		.i_wbStrobe (wbStrobe),
		.i_wbRow    (wbRow),
		.i_macIn    (macData),
		.i_irIn     (irData),
		.i_satIn    (satBit),
		.o_matElem  (matElem),
		.o_vecElem  (vecElem),
		.o_irElem   (irElem),
		.o_trElem   (trElem)
	);

	// Microcode control
	vecSequencer u_sequencer (
		.i_clk    (i_clk),
		.i_arstN  (i_arstN),
		.i_start  (start),
		.i_opcode (instr[5:0]),
		.o_busy   (busy),
		.o_step   (step)
	);

	vecDatapath #(
		.fracBits (fracBits)
	) u_datapath (
		.i_clk      (i_clk),
		.i_arstN    (i_arstN),
		.i_step     (step),
		.i_matElem  (matElem),
		.i_vecElem  (vecElem),
		.i_irElem   (irElem),
		.i_trElem   (trElem),
		.i_sf       (instr[instrSfBit]),
		.i_lm       (instr[instrLmBit]),
		.i_transEn  (instr[instrTransBit]),
		.o_wbStrobe (wbStrobe),
		.o_wbRow    (wbRow),
		.o_macOut   (macData),
		.o_irOut    (irData),
		.o_satOut   (satBit)
	);

endmodule

/* tests/tbClock.sv */
module tbClock #(
	parameter int resetCycles = 3
) (
	output logic o_clk,
	output logic o_arstN
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		o_clk = 1'b0;
		forever #2 o_clk = ~o_clk;  // 4 ns period
	end

	// Reset released just after an edge
	initial begin
		o_arstN = 1'b0;
		repeat (resetCycles) @(posedge o_clk);
		#1 o_arstN = 1'b1;
	end

endmodule

/* tests/tbVecEngine.sv */
module tbVecEngine import vecPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int fracBits = 12;
	localparam int numTests = 6;
	localparam int mvmvaBusy = 10;  // Busy cycles of one MVMVA

	logic clk, arstN, wbCyc, wbStb, wbWe;
	regAdrType wbAdr;
	wordType wbDatIn, wbDatOut, expData;
	logic wbAck, rdActive;
	int errCount = 0, passCount = 0, failCount = 0, errBefore;
	integer seed = 32'he3dd2704;

	// Reference state
	int vec [0:8], mat [0:8], tr [0:2], ir [0:2];
	wordType mac [0:2];
	logic [2:0] flag;

	tbClock clkGen (.o_clk(clk), .o_arstN(arstN));

	vecEngine #(.fracBits(fracBits)) i_vecEngine (
		.i_clk(clk), .i_arstN(arstN), .i_wbCyc(wbCyc), .i_wbStb(wbStb), .i_wbWe(wbWe),
		.i_wbAdr(wbAdr), .i_wbDat(wbDatIn), .o_wbDat(wbDatOut), .o_wbAck(wbAck)
	);

	// Every checked read is compared in its ack cycle
	readMatches: assert property (@(posedge clk) disable iff (!arstN)
		(wbAck && rdActive) |-> (wbDatOut == expData))
	else begin
		errCount++;
		$display("** Error: %0t ns: read of adr %0d gave %h, expected %h",
			$time, wbAdr, wbDatOut, expData);
	end

	// ------------------------------
	// Bus tasks
	// ------------------------------
	task automatic busWrite(input regAdrType adr, input wordType data, output int waits);
		waits = 0;
		@(posedge clk);
		#1;
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = 1'b1;
		wbAdr = adr;
		wbDatIn = data;
		do begin
			@(posedge clk);
			#1;
			waits++;
		end while (!wbAck);
		@(posedge clk);  // Ack taken on this edge
		#1;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
	endtask

	task automatic busRead(input regAdrType adr, input logic check, input wordType exp,
		output wordType data);
		@(posedge clk);
		#1;
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = 1'b0;
		wbAdr = adr;
		expData = exp;
		rdActive = check;
		do begin
			@(posedge clk);
			#1;
		end while (!wbAck);
		data = wbDatOut;
		@(posedge clk);
		#1;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		rdActive = 1'b0;
	endtask

	task automatic writeReg(input regAdrType adr, input wordType data);
		int waits;
		busWrite(adr, data, waits);
	endtask

	task automatic checkReg(input regAdrType adr, input wordType exp);
		wordType d;
		busRead(adr, 1'b1, exp, d);
	endtask

	// Poll CMD until busy clears
	task automatic waitIdle();
		wordType d;
		int polls;
		polls = 0;
		do begin
			busRead(adrCmd, 1'b0, '0, d);
			polls++;
		end while (d[0] && polls < 40);
		if (d[0]) begin
			errCount++;
			$display("Engine still busy after %0d polls at %0t ns", polls, $time);
		end
	endtask

	function automatic wordType makeInstr(input opcodeType op, input logic sf, input logic lm,
		input logic trans, input logic [1:0] vsel);
		wordType w;
		w = '0;
		w[5:0] = op;
		w[instrLmBit] = lm;
		w[instrTransBit] = trans;
		w[instrVecLsb +: 2] = vsel;
		w[instrSfBit] = sf;
		return w;
	endfunction

	// ------------------------------
	// Reference model
	// ------------------------------
	function automatic int clampRow(input int r, input longint acc, input logic sf,
		input logic lm);
		longint sh, lo;
		sh = sf ? (acc >>> fracBits) : acc;
		lo = lm ? 0 : -32768;
		mac[r] = sh[31:0];
		flag[r] = (sh > 32767) || (sh < lo);
		if (sh > 32767) return 32767;
		if (sh < lo) return int'(lo);
		return int'(sh);
	endfunction

	function automatic void modelMvmva(input logic sf, input logic lm, input logic trans,
		input int vsel);
		int irNew [0:2];
		longint acc;
		flag = '0;
		for (int r = 0; r < 3; r++) begin
			acc = trans ? (longint'(tr[r]) <<< fracBits) : 0;
			for (int c = 0; c < 3; c++)
				acc += longint'(mat[r*3+c]) * ((vsel == 3) ? ir[c] : vec[vsel*3+c]);
			irNew[r] = clampRow(r, acc, sf, lm);
		end
		ir = irNew;  // IR operands were read before any row landed
	endfunction

	function automatic void modelSqr(input logic sf, input logic lm);
		int irNew [0:2];
		flag = '0;
		for (int r = 0; r < 3; r++)
			irNew[r] = clampRow(r, longint'(ir[r]) * ir[r], sf, lm);
		ir = irNew;
	endfunction

	// Random operands with TR narrowed to 20 bits unless fullTr
	task automatic loadOperands(input logic fullTr);
		wordType d;
		for (int i = 0; i < 9; i++) begin
			d = $random(seed);
			writeReg(regAdrType'(i), d);
			vec[i] = int'($signed(d[15:0]));
			d = $random(seed);
			writeReg(adrMatBase + regAdrType'(i), d);
			mat[i] = int'($signed(d[15:0]));
		end
		for (int i = 0; i < 3; i++) begin
			tr[i] = $random(seed);
			if (!fullTr) tr[i] = tr[i] >>> 12;
			writeReg(adrTrBase + regAdrType'(i), wordType'(tr[i]));
		end
	endtask

	task automatic checkResults();
		for (int r = 0; r < 3; r++) begin
			checkReg(adrMacBase + regAdrType'(r), mac[r]);
			checkReg(adrIrBase + regAdrType'(r), wordType'(ir[r]));
		end
		checkReg(adrFlag, {29'd0, flag});
	endtask

	task automatic runCmd(input wordType cmd);
		writeReg(adrCmd, cmd);
		waitIdle();
	endtask

	task automatic endTest(input string name);
		if (errCount == errBefore) passCount++;
		else failCount++;
		$display("Test %s: %s (%0d errors)", name,
			(errCount == errBefore) ? "ok" : "failed", errCount - errBefore);
		errBefore = errCount;
	endtask

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial begin
		int waits;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatIn = '0;
		expData = '0;
		rdActive = 1'b0;
		flag = '0;
		errBefore = 0;
		@(posedge arstN);

		loadOperands(1'b1);  // 16-bit fields come back sign-extended
		for (int i = 0; i < 9; i++) begin
			checkReg(regAdrType'(i), wordType'(vec[i]));
			checkReg(adrMatBase + regAdrType'(i), wordType'(mat[i]));
		end
		for (int i = 0; i < 3; i++) checkReg(adrTrBase + regAdrType'(i), wordType'(tr[i]));
		endTest("readback");

		for (int v = 0; v < 4; v++) begin
			loadOperands(1'b0);
			runCmd(makeInstr(opMvmva, 1'b1, 1'b0, 1'b1, 2'(v)));
			modelMvmva(1'b1, 1'b0, 1'b1, v);
			checkResults();
		end
		endTest("mvmva");

		for (int i = 0; i < 9; i++) begin
			mat[i] = (i < 3) ? 20000 : (i < 6) ? -20000 : ((i == 6) ? 1 : 0);
			writeReg(adrMatBase + regAdrType'(i), wordType'(mat[i]));
			vec[i] = (i < 3) ? 20000 : 0;  // V2 all zero
			writeReg(regAdrType'(i), wordType'(vec[i]));
		end
		for (int lm = 0; lm < 2; lm++) begin
			runCmd(makeInstr(opMvmva, 1'b0, 1'(lm), 1'b0, 2'd0));
			modelMvmva(1'b0, 1'(lm), 1'b0, 0);
			checkResults();
		end
		runCmd(makeInstr(opMvmva, 1'b0, 1'b0, 1'b0, 2'd2));  // Nothing clamps
		modelMvmva(1'b0, 1'b0, 1'b0, 2);
		checkResults();
		endTest("saturation");

		loadOperands(1'b0);
		runCmd(makeInstr(opMvmva, 1'b1, 1'b0, 1'b1, 2'd1));
		modelMvmva(1'b1, 1'b0, 1'b1, 1);
		for (int s = 1; s >= 0; s--) begin
			runCmd(makeInstr(opSqr, 1'(s), 1'b0, 1'b0, 2'd0));
			modelSqr(1'(s), 1'b0);
			checkResults();
		end
		endTest("sqr");

		// Host write lands in the middle of a run
		loadOperands(1'b0);
		writeReg(adrCmd, makeInstr(opMvmva, 1'b1, 1'b0, 1'b1, 2'd0));
		busWrite(5'd0, 32'h0000_1234, waits);
		modelMvmva(1'b1, 1'b0, 1'b1, 0);
		vec[0] = 32'h1234;
		// Issued one cycle into the run, so the ack waits out all busy cycles
		assert (waits >= mvmvaBusy) else begin
			errCount++;
			$display("Write during busy was acknowledged after only %0d cycles", waits);
		end
		checkReg(adrCmd, 32'd0);
		checkResults();
		checkReg(5'd0, 32'h0000_1234);
		endTest("backpressure");

		runCmd(makeInstr(6'h3f, 1'b1, 1'b1, 1'b1, 2'd3));
		flag = '0;  // Start still clears FLAG
		checkResults();
		endTest("nop");

		$display("Tests passed %0d failed %0d", passCount, failCount);
		if (failCount == 0 && errCount == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		#(numTests * 2000);
		$display("Watchdog expired, the tests did not finish in time");
		$display("Result: FAILED");
		$finish;
	end

endmodule

/* tb.f */
rtl/vecPkg.sv
rtl/vecRegFile.sv
rtl/vecSequencer.sv
rtl/vecDatapath.sv
rtl/vecEngine.sv
tests/tbClock.sv
tests/tbVecEngine.sv

/* Makefile */
TOP = tbVecEngine
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f -o sim
	./obj_dir/sim | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
